// ==== agucam_consts.svh ====
`ifndef AGUCAM_CONSTS_SVH
`define AGUCAM_CONSTS_SVH

// replay buffer geometry
`define CAM_DEPTH   8
`define CAM_AW      3
`define CAM_LANES   4
`define CAM_STALL   4

// address and register widths
`define VADDR_W     44
`define PADDR_W     36
`define REG_W       9

// store payload
`define DATA_W      136

// tags carried through unchanged
`define LSQ_W       9
`define II_W        10
`define WQ_W        8

// load and store forms share one body word
`define BODY_W      80
// thread, lsflag, attr and invtlb take the last 7 bits
`define LD_SPARE_W  (`BODY_W - `VADDR_W - `LSQ_W - 7)

`endif

// ==== agucam_pkg.sv ====
`include "agucam_consts.svh"

package agucam_pkg;

  // fields every memory op carries
  typedef struct packed {
    logic [`REG_W-1:0] reg_no;
    logic [1:0]        mtype;
    logic [4:0]        sz;
    logic              split;
    logic [4:0]        bank0;
    logic [`II_W-1:0]  ii;
    logic [`WQ_W-1:0]  wq;
  } op_common_t;

  typedef struct packed {
    logic [`LD_SPARE_W-1:0] spare;
    logic [`VADDR_W-1:0]    addr_main;
    logic [`LSQ_W-1:0]      lsq;
    logic                   thread;
    logic                   lsflag;
    logic [3:0]             attr;
    logic                   invtlb;
  } load_fields_t;

  // even/odd bank pair addresses
  typedef struct packed {
    logic [`PADDR_W-1:0] addr_even;
    logic [`PADDR_W-1:0] addr_odd;
    logic                odd;
    logic [1:0]          low;
    logic [4:0]          bread;
  } store_fields_t;

  // same bits, decoded by lsfw
  typedef union packed {
    load_fields_t  ld;
    store_fields_t st;
  } op_body_u;

  typedef struct packed {
    op_common_t   com;
    load_fields_t fld;
  } load_op_t;

  typedef struct packed {
    op_common_t          com;
    store_fields_t       fld;
    logic [`DATA_W-1:0]  data;
  } store_op_t;

  // one buffered group, bit 3 of confl is the store
  typedef struct packed {
    logic [`CAM_LANES-1:0]     confl;
    load_op_t [`CAM_LANES-2:0] ld;
    store_op_t                 st;
  } cam_row_t;

  typedef struct packed {
    logic               lsfw;
    op_common_t         com;
    op_body_u           body;
    logic [`DATA_W-1:0] data;
  } mop_out_t;

endpackage

// ==== agucam_capture.sv ====
`timescale 1ns/10ps
`include "agucam_consts.svh"

module agucam_capture import agucam_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  load_op_t [`CAM_LANES-2:0] load_in,
  input  store_op_t                 store_in,
  input  logic [`CAM_LANES-1:0]     conflict,
  input  logic                      except,
  output cam_row_t                  row,
  output logic                      wr_en
);

  logic [`CAM_LANES-1:0]     conf_q;
  load_op_t [`CAM_LANES-2:0] ld_q;
  store_op_t                 st_q;

  // group seen together with an except is dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      conf_q <= '0;
    end else if (except) begin
      conf_q <= '0;
    end else begin
      conf_q <= conflict;
    end
  end

  // payload only matters when some lane conflicts
  always_ff @(posedge clk) begin
    if (|conflict) begin
      ld_q <= load_in;
      st_q <= store_in;
    end
  end

  always_comb begin
    row.confl = conf_q;
    row.ld    = ld_q;
    row.st    = st_q;
  end

  // second chance to drop it if except arrives one cycle late
  assign wr_en = (|conf_q) && !except;

endmodule

// ==== agucam_row_buffer.sv ====
`timescale 1ns/10ps
`include "agucam_consts.svh"

module agucam_row_buffer import agucam_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     except,
  input  cam_row_t row,
  input  logic     wr_en,
  input  logic     pop,
  output cam_row_t head_row,
  output logic     head_valid,
  output logic     do_skip
);

  cam_row_t              mem [`CAM_DEPTH];
  logic [`CAM_DEPTH-1:0] valid;
  logic [`CAM_AW-1:0]    head_ptr;
  logic [`CAM_AW-1:0]    tail_ptr;
  logic [`CAM_AW:0]      count;
  logic [`CAM_AW:0]      count_nxt;
  logic                  full;
  logic                  do_wr;
  logic                  do_pop;

  // tail slot still occupied means every slot is
  assign full       = valid[tail_ptr];
  assign do_wr      = wr_en && !full;
  assign head_valid = valid[head_ptr];
  assign do_pop     = pop && head_valid;
  assign head_row   = mem[head_ptr];

  always_comb begin
    count_nxt = count;
    if (except) begin
      count_nxt = '0;
    end else if (do_wr && !do_pop) begin
      count_nxt = count + 1'b1;
    end else if (do_pop && !do_wr) begin
      count_nxt = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[tail_ptr] <= row;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid    <= '0;
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
      do_skip  <= 1'b0;
    end else begin
      if (except) begin
        valid    <= '0;
        head_ptr <= '0;
        tail_ptr <= '0;
      end else begin
        if (do_wr) begin
          valid[tail_ptr] <= 1'b1;
          tail_ptr        <= tail_ptr + 1'b1;
        end
        if (do_pop) begin
          valid[head_ptr] <= 1'b0;
          head_ptr        <= head_ptr + 1'b1;
        end
      end
      count <= count_nxt;
      // set at threshold, held until fully drained
      if (count_nxt >= `CAM_STALL) begin
        do_skip <= 1'b1;
      end else if (count_nxt == '0) begin
        do_skip <= 1'b0;
      end
    end
  end

endmodule

// ==== agucam_replay_select.sv ====
`timescale 1ns/10ps
`include "agucam_consts.svh"

module agucam_replay_select import agucam_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     except,
  input  logic     read_clkEn,
  input  cam_row_t head_row,
  input  logic     head_valid,
  output mop_out_t mop_out,
  output logic     out_en,
  output logic     pop
);

  logic [`CAM_LANES-1:0]         pending;
  logic [`CAM_LANES-1:0]         sel;
  logic [$clog2(`CAM_LANES)-1:0] lane;
  logic                          store_sel;

  // lowest pending lane wins
  always_comb begin
    lane = '0;
    for (int i = `CAM_LANES - 1; i >= 0; i--) begin
      if (pending[i]) begin
        lane = i[$clog2(`CAM_LANES)-1:0];
      end
    end
  end

  assign sel       = {{(`CAM_LANES-1){1'b0}}, 1'b1} << lane;
  assign store_sel = (lane == `CAM_LANES - 1);

  assign out_en = read_clkEn && head_valid && !except && (|pending);
  // last lane of the row retires it
  assign pop    = out_en && ((pending & ~sel) == '0);

  always_comb begin
    mop_out = '0;
    if (store_sel) begin
      mop_out.lsfw    = 1'b1;
      mop_out.com     = head_row.st.com;
      mop_out.body.st = head_row.st.fld;
      mop_out.data    = head_row.st.data;
    end else begin
      mop_out.lsfw    = 1'b0;
      mop_out.com     = head_row.ld[lane].com;
      mop_out.body.ld = head_row.ld[lane].fld;
    end
  end

  // empty mask means the head row has not been picked up yet
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else if (except || pop) begin
      pending <= '0;
    end else if (out_en) begin
      pending <= pending & ~sel;
    end else if (read_clkEn && head_valid && pending == '0) begin
      pending <= head_row.confl;
    end
  end

endmodule

// ==== agucam_top.sv ====
`timescale 1ns/10ps
`include "agucam_consts.svh"

module agucam_top import agucam_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  load_op_t [`CAM_LANES-2:0] load_in,
  input  store_op_t                 store_in,
  input  logic [`CAM_LANES-1:0]     conflict,
  input  logic                      except,
  input  logic                      read_clkEn,
  output mop_out_t                  mop_out,
  output logic                      out_en,
  output logic                      do_skip
);

  cam_row_t cap_row;
  logic     cap_wr_en;
  cam_row_t head_row;
  logic     head_valid;
  logic     pop;

  agucam_capture capture_i (
    .clk      (clk),
    .rst      (rst),
    .load_in  (load_in),
    .store_in (store_in),
    .conflict (conflict),
    .except   (except),
    .row      (cap_row),
    .wr_en    (cap_wr_en)
  );

  agucam_row_buffer buffer_i (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .row        (cap_row),
    .wr_en      (cap_wr_en),
    .pop        (pop),
    .head_row   (head_row),
    .head_valid (head_valid),
    .do_skip    (do_skip)
  );

  // replays the head row one lane per cycle
  agucam_replay_select select_i (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .read_clkEn (read_clkEn),
    .head_row   (head_row),
    .head_valid (head_valid),
    .mop_out    (mop_out),
    .out_en     (out_en),
    .pop        (pop)
  );

endmodule

// ==== agucam_props.sv ====
`timescale 1ns/10ps

module agucam_props (
  input logic clk,
  input logic rst,
  input logic except,
  input logic read_clkEn,
  input logic out_en,
  input logic do_skip,
  input logic head_valid
);

  // nothing active in the cycle after reset
  reset_quiet: assert property (@(posedge clk) rst |=> (!out_en && !do_skip && !head_valid))
    else $error("outputs active right after reset");

  // flushed buffer has nothing left to replay
  flush_blocks_out: assert property (@(posedge clk) disable iff (rst)
    except |-> !out_en ##1 !out_en)
    else $error("out_en high during or right after except");

  // held head row stays put
  held_no_out: assert property (@(posedge clk) disable iff (rst)
    (!read_clkEn && head_valid && !except) |-> !out_en ##1 head_valid)
    else $error("head row replayed or retired while read_clkEn low");

  // stall only with rows present
  skip_needs_rows: assert property (@(posedge clk) disable iff (rst) do_skip |-> head_valid)
    else $error("do_skip set with an empty buffer");

  flush_empties: assert property (@(posedge clk) disable iff (rst) except |=> !head_valid)
    else $error("buffer not empty after except");

endmodule

bind agucam_top agucam_props props_i (
  .clk        (clk),
  .rst        (rst),
  .except     (except),
  .read_clkEn (read_clkEn),
  .out_en     (out_en),
  .do_skip    (do_skip),
  .head_valid (head_valid)
);

// ==== agucam_tb.sv ====
`timescale 1ns/10ps
`include "agucam_consts.svh"

module agucam_tb import agucam_pkg::*; ();

  localparam int NUM_GROUPS = 14;

  logic                      clk;
  logic                      rst;
  load_op_t [`CAM_LANES-2:0] load_in;
  store_op_t                 store_in;
  logic [`CAM_LANES-1:0]     conflict;
  logic                      except;
  logic                      read_clkEn;
  mop_out_t                  mop_out;
  logic                      out_en;
  logic                      do_skip;

  mop_out_t exp_q[$];
  int       errors;
  int       tests_run;
  logic     skip_q;

  agucam_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .load_in    (load_in),
    .store_in   (store_in),
    .conflict   (conflict),
    .except     (except),
    .read_clkEn (read_clkEn),
    .mop_out    (mop_out),
    .out_en     (out_en),
    .do_skip    (do_skip)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic load_op_t rand_load();
    logic [$bits(load_op_t)-1:0] v;
    for (int i = 0; i < $bits(load_op_t); i++) begin
      v[i] = 1'($urandom);
    end
    return load_op_t'(v);
  endfunction

  function automatic store_op_t rand_store();
    logic [$bits(store_op_t)-1:0] v;
    for (int i = 0; i < $bits(store_op_t); i++) begin
      v[i] = 1'($urandom);
    end
    return store_op_t'(v);
  endfunction

  // loads leave in load form with zero data, the store keeps its data
  task automatic send_group(input logic [`CAM_LANES-1:0] c);
    load_op_t [`CAM_LANES-2:0] lds;
    store_op_t                 st;
    mop_out_t                  m;
    for (int i = 0; i < `CAM_LANES - 1; i++) begin
      lds[i] = rand_load();
    end
    st = rand_store();
    @(posedge clk);
    load_in  <= lds;
    store_in <= st;
    conflict <= c;
    for (int i = 0; i < `CAM_LANES - 1; i++) begin
      if (c[i]) begin
        m         = '0;
        m.com     = lds[i].com;
        m.body.ld = lds[i].fld;
        exp_q.push_back(m);
      end
    end
    if (c[`CAM_LANES-1]) begin
      m         = '0;
      m.lsfw    = 1'b1;
      m.com     = st.com;
      m.body.st = st.fld;
      m.data    = st.data;
      exp_q.push_back(m);
    end
    @(posedge clk);
    conflict <= '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_empty(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("expected ops still queued at %0t, the DUT stopped replaying", $time);
    end
    idle(4);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d (%s) finished, errors so far %0d", tests_run, name, errors);
  endtask

  // output checks sampled away from the driving edge
  always @(negedge clk) begin
    if (!rst) begin
      if (out_en) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("out_en at %0t with no op expected", $time);
        end
        if (exp_q.size() != 0) begin
          assert (mop_out == exp_q[0]) else begin
            errors++;
            $display("Error at %0t: mop_out got %h expected %h", $time, mop_out, exp_q[0]);
          end
          void'(exp_q.pop_front());
        end
      end
      assert (!(skip_q && !do_skip) || exp_q.size() == 0) else begin
        errors++;
        $display("do_skip fell at %0t while %0d ops were still queued", $time, exp_q.size());
      end
    end
    skip_q <= do_skip;
  end

  initial begin
    repeat (40 * NUM_GROUPS + 200) @(posedge clk);
    $display("watchdog expired at %0t", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hcedb_3ac4));
    errors     = 0;
    tests_run  = 0;
    rst        = 1'b1;
    load_in    = '0;
    store_in   = '0;
    conflict   = '0;
    except     = 1'b0;
    read_clkEn = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // idle after reset
    repeat (6) begin
      @(negedge clk);
      assert (!out_en && !do_skip) else begin
        errors++;
        $display("out_en or do_skip active at %0t before any group", $time);
      end
    end
    finish_test("idle after reset");

    @(posedge clk);
    read_clkEn <= 1'b1;
    send_group(4'b0010);
    wait_empty(30);
    finish_test("single load lane");

    send_group(4'b1101);
    send_group(4'b1010);
    wait_empty(40);
    finish_test("lane order with store");

    @(posedge clk);
    read_clkEn <= 1'b0;
    send_group(4'b0001);
    send_group(4'b1100);
    send_group(4'b0110);
    idle(6);
    read_clkEn <= 1'b1;
    wait_empty(60);
    finish_test("back-pressure");

    @(posedge clk);
    read_clkEn <= 1'b0;
    for (int g = 0; g < 4; g++) begin
      send_group(4'(($urandom % 15) + 1));
    end
    idle(3);
    @(negedge clk);
    assert (do_skip) else begin
      errors++;
      $display("Error at %0t: do_skip got %b expected 1", $time, do_skip);
    end
    @(posedge clk);
    read_clkEn <= 1'b1;
    wait_empty(80);
    @(negedge clk);
    assert (!do_skip) else begin
      errors++;
      $display("Error at %0t: do_skip got %b expected 0", $time, do_skip);
    end
    finish_test("stall threshold");

    @(posedge clk);
    read_clkEn <= 1'b0;
    send_group(4'b1011);
    send_group(4'b0111);
    idle(3);
    except <= 1'b1;
    exp_q.delete();
    @(posedge clk);
    except     <= 1'b0;
    read_clkEn <= 1'b1;
    idle(8);
    send_group(4'b1001);
    send_group(4'b0100);
    wait_empty(40);
    finish_test("except flush");

    if (errors == 0) begin
      $display("%0d tests run, 0 errors", tests_run);
      $display("TESTBENCH PASSED");
    end else begin
      $display("%0d tests run, %0d errors", tests_run, errors);
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
agucam_pkg.sv
agucam_capture.sv
agucam_row_buffer.sv
agucam_replay_select.sv
agucam_top.sv
agucam_props.sv
agucam_tb.sv

// ==== Makefile ====
SRCS := agucam_consts.svh agucam_pkg.sv agucam_capture.sv agucam_row_buffer.sv \
        agucam_replay_select.sv agucam_top.sv agucam_props.sv agucam_tb.sv

.PHONY: all run clean

all: obj_dir/Vagucam_tb

obj_dir/Vagucam_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wall -Wno-fatal \
		--top-module agucam_tb -Mdir obj_dir -f vlog.f

run: obj_dir/Vagucam_tb
	@out="$$(./obj_dir/Vagucam_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
